//--- hw/axis_in_pkg.sv
//********************************************************************
// Stream input peripheral shared definitions
// Bus widths, FIFO depth and the register map
//********************************************************************

package axis_in_pkg;

   // Read word and register width
   localparam int DATA_W = 32;

   // Stream beat width
   localparam int TDATA_W = 8;

   // log2 of FIFO depth in beats (16 beats, 4 words)
   localparam int FIFO_ADDR_W = 4;

   // Wishbone word address width
   localparam int CSR_ADDR_W = 3;

   // Register word addresses
   typedef enum logic [CSR_ADDR_W-1:0] {
      // bit0 enable, bit1 soft reset
      CSR_CTRL   = 3'd0,
      // bit0 empty, bit1 full, bit2 tlast detected
      CSR_STATUS = 3'd1,
      // Read pops one word
      CSR_DATA   = 3'd2,
      // Words held, prefetch included
      CSR_LEVEL  = 3'd3,
      // Accepted beats
      CSR_NWORDS = 3'd4,
      // Interrupt threshold
      CSR_THRESH = 3'd5
   } csr_addr_e;

endpackage

//--- hw/axis_in_sync.sv
//********************************************************************
// Two-stage synchronizer for a bus entering a clock domain
//********************************************************************

`timescale 1ns/1ps

module axis_in_sync #(
   parameter int WIDTH = 1
) (
   input  logic             clk_i,
   input  logic             arst_n_i,
   input  logic [WIDTH-1:0] data_i,
   output logic [WIDTH-1:0] data_o
);

   logic [WIDTH-1:0] meta_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         meta_q <= '0;
         data_o <= '0;
      end else begin
         meta_q <= data_i;
         data_o <= meta_q;
      end
   end

endmodule

//--- hw/axis_in_async_fifo.sv
//********************************************************************
// Dual-clock FIFO, byte-wide write port and word-wide read port
// Gray-coded pointers cross between the two domains
//********************************************************************

`timescale 1ns/1ps

module axis_in_async_fifo #(
   parameter int DATA_W      = axis_in_pkg::DATA_W,
   parameter int TDATA_W     = axis_in_pkg::TDATA_W,
   parameter int FIFO_ADDR_W = axis_in_pkg::FIFO_ADDR_W
) (
   input  logic                   arst_n_i,
   // Write side
   input  logic                   w_clk_i,
   input  logic                   w_rst_i,
   input  logic                   w_en_i,
   input  logic [    TDATA_W-1:0] w_data_i,
   output logic                   w_full_o,
   // Read side
   input  logic                   r_clk_i,
   input  logic                   r_rst_i,
   input  logic                   r_en_i,
   output logic [     DATA_W-1:0] r_data_o,
   output logic                   r_empty_o,
   output logic                   r_full_o,
   output logic [FIFO_ADDR_W:0]   r_level_o
);

   localparam int R     = DATA_W / TDATA_W;
   localparam int R_W   = $clog2(R);
   localparam int WA_W  = FIFO_ADDR_W - R_W;
   localparam int DEPTH = 1 << FIFO_ADDR_W;

   logic [TDATA_W-1:0] mem[DEPTH];

   // Write pointer counts beats, read pointer counts words
   logic [FIFO_ADDR_W:0] w_bin_q, w_gray_q, w_bin_nxt, w_used, r_beats_w;
   logic [FIFO_ADDR_W:0] w_gray_r, w_bin_r;
   logic [WA_W:0]        r_bin_q, r_gray_q, r_bin_nxt, r_gray_w, r_level;

   logic w_push, r_pop;

   function automatic logic [FIFO_ADDR_W:0] gray2bin(input logic [FIFO_ADDR_W:0] g);
      logic [FIFO_ADDR_W:0] b;
      b[FIFO_ADDR_W] = g[FIFO_ADDR_W];
      for (int i = FIFO_ADDR_W - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // Write domain
   assign r_beats_w = {gray2bin(FIFO_ADDR_W'(r_gray_w))[WA_W:0], {R_W{1'b0}}};
   assign w_used    = w_bin_q - r_beats_w;
   assign w_full_o  = w_used[FIFO_ADDR_W];
   assign w_push    = w_en_i & ~w_full_o;
   assign w_bin_nxt = w_bin_q + 1'b1;

   always_ff @(posedge w_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         w_bin_q  <= '0;
         w_gray_q <= '0;
      end else if (w_rst_i) begin
         w_bin_q  <= '0;
         w_gray_q <= '0;
      end else if (w_push) begin
         w_bin_q  <= w_bin_nxt;
         w_gray_q <= w_bin_nxt ^ (w_bin_nxt >> 1);
      end
   end

   always_ff @(posedge w_clk_i) begin
      if (w_push) begin
         mem[w_bin_q[FIFO_ADDR_W-1:0]] <= w_data_i;
      end
   end

   // Read domain, only complete words count
   assign w_bin_r   = gray2bin(w_gray_r);
   assign r_level   = w_bin_r[FIFO_ADDR_W:R_W] - r_bin_q;
   assign r_empty_o = (r_level == '0);
   assign r_full_o  = r_level[WA_W];
   assign r_level_o = (FIFO_ADDR_W + 1)'(r_level);
   assign r_pop     = r_en_i & ~r_empty_o;
   assign r_bin_nxt = r_bin_q + 1'b1;

   always_ff @(posedge r_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_bin_q  <= '0;
         r_gray_q <= '0;
      end else if (r_rst_i) begin
         r_bin_q  <= '0;
         r_gray_q <= '0;
      end else if (r_pop) begin
         r_bin_q  <= r_bin_nxt;
         r_gray_q <= r_bin_nxt ^ (r_bin_nxt >> 1);
      end
   end

   // First byte of a word lands in the low bits
   always_comb begin
      for (int k = 0; k < R; k++) begin
         r_data_o[k*TDATA_W+:TDATA_W] = mem[r_bin_q[WA_W-1:0]*R + k];
      end
   end

   axis_in_sync #(.WIDTH(FIFO_ADDR_W + 1)) w_ptr_sync (
      .clk_i   (r_clk_i),
      .arst_n_i(arst_n_i),
      .data_i  (w_gray_q),
      .data_o  (w_gray_r)
   );

   axis_in_sync #(.WIDTH(WA_W + 1)) r_ptr_sync (
      .clk_i   (w_clk_i),
      .arst_n_i(arst_n_i),
      .data_i  (r_gray_q),
      .data_o  (r_gray_w)
   );

   // Both neighbours must honour the flags
   a_no_overflow : assert property (@(posedge w_clk_i) disable iff (!arst_n_i)
      !(w_en_i && w_full_o));
   a_no_underflow : assert property (@(posedge r_clk_i) disable iff (!arst_n_i)
      !(r_en_i && r_empty_o));

endmodule

//--- hw/axis_in_write_ctrl.sv
//********************************************************************
// Stream side control: ready, zero padding, beat count, tlast latch
//********************************************************************

`timescale 1ns/1ps

module axis_in_write_ctrl #(
   parameter int TDATA_W = axis_in_pkg::TDATA_W,
   parameter int DATA_W  = axis_in_pkg::DATA_W
) (
   input  logic               axis_clk_i,
   input  logic               arst_n_i,
   input  logic               sw_rst_i,
   input  logic               sw_enable_i,
   input  logic               axis_tvalid_i,
   input  logic [TDATA_W-1:0] axis_tdata_i,
   input  logic               axis_tlast_i,
   output logic               axis_tready_o,
   input  logic               fifo_full_i,
   output logic               fifo_wr_en_o,
   output logic [TDATA_W-1:0] fifo_wr_data_o,
   output logic [ DATA_W-1:0] count_gray_o,
   output logic               tlast_seen_o
);

   localparam int R   = DATA_W / TDATA_W;
   localparam int R_W = $clog2(R);

   typedef enum logic {
      IDLE,
      PAD
   } state_e;

   state_e            state_q, state_nxt;
   logic [   R_W-1:0] pos_q;
   logic [DATA_W-1:0] count_q, count_nxt;
   logic              beat, word_last;

   assign axis_tready_o  = sw_enable_i & ~fifo_full_i & ~tlast_seen_o & (state_q == IDLE);
   assign beat           = axis_tvalid_i & axis_tready_o;
   assign fifo_wr_en_o   = beat | ((state_q == PAD) & ~fifo_full_i);
   assign fifo_wr_data_o = (state_q == PAD) ? '0 : axis_tdata_i;
   // This write closes the current word
   assign word_last      = &pos_q;
   assign count_nxt      = count_q + 1'b1;

   always_comb begin
      state_nxt = state_q;
      case (state_q)
         IDLE: if (beat && axis_tlast_i && !word_last) state_nxt = PAD;
         PAD:  if (!fifo_full_i && word_last) state_nxt = IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge axis_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q      <= IDLE;
         pos_q        <= '0;
         count_q      <= '0;
         count_gray_o <= '0;
         tlast_seen_o <= 1'b0;
      end else if (sw_rst_i) begin
         state_q      <= IDLE;
         pos_q        <= '0;
         count_q      <= '0;
         count_gray_o <= '0;
         tlast_seen_o <= 1'b0;
      end else begin
         state_q <= state_nxt;
         // Position counts pad bytes too
         if (fifo_wr_en_o) pos_q <= pos_q + 1'b1;
         if (beat) begin
            count_q      <= count_nxt;
            count_gray_o <= count_nxt ^ (count_nxt >> 1);
         end
         if (beat && axis_tlast_i) tlast_seen_o <= 1'b1;
      end
   end

   // Closed packet always ends on a word boundary once padding is done
   a_closed_packet : assert property (@(posedge axis_clk_i) disable iff (!arst_n_i)
      tlast_seen_o && (state_q == IDLE) |-> pos_q == '0);

endmodule

//--- hw/axis_in_csr.sv
//********************************************************************
// Wishbone classic register file with read word prefetch,
// level tracking and threshold interrupt
//********************************************************************

`timescale 1ns/1ps

module axis_in_csr #(
   parameter int DATA_W      = axis_in_pkg::DATA_W,
   parameter int FIFO_ADDR_W = axis_in_pkg::FIFO_ADDR_W
) (
   input  logic                              clk_i,
   input  logic                              arst_n_i,
   // Wishbone slave
   input  logic                              wb_cyc_i,
   input  logic                              wb_stb_i,
   input  logic                              wb_we_i,
   input  logic [axis_in_pkg::CSR_ADDR_W-1:0] wb_adr_i,
   input  logic [               DATA_W-1:0]  wb_dat_i,
   input  logic [             DATA_W/8-1:0]  wb_sel_i,
   output logic [               DATA_W-1:0]  wb_dat_o,
   output logic                              wb_ack_o,
   // Control
   output logic                              enable_o,
   output logic                              soft_reset_o,
   // FIFO read side
   output logic                              fifo_rd_en_o,
   input  logic [               DATA_W-1:0]  fifo_rd_data_i,
   input  logic                              fifo_rd_empty_i,
   input  logic                              fifo_rd_full_i,
   input  logic [            FIFO_ADDR_W:0]  fifo_rd_level_i,
   // Synchronized from the stream domain
   input  logic [               DATA_W-1:0]  count_gray_i,
   input  logic                              tlast_seen_i,
   output logic                              interrupt_o
);

   import axis_in_pkg::*;

   logic              req, rd_req, wr_req, data_pop;
   logic [DATA_W-1:0] thresh_q, pf_data_q, rd_data, count_bin;
   logic [FIFO_ADDR_W:0] level;
   logic              pf_valid_q, empty;
   csr_addr_e         addr;

   assign addr   = csr_addr_e'(wb_adr_i);
   assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
   // Byte lanes in wb_sel_i are not decoded, every write is full-word
   assign rd_req = req & ~wb_we_i;
   assign wr_req = req & wb_we_i;

   // Prefetch register refills whenever it is free
   assign fifo_rd_en_o = ~pf_valid_q & ~fifo_rd_empty_i & ~soft_reset_o;
   assign data_pop     = rd_req & (addr == CSR_DATA) & pf_valid_q;
   assign level        = fifo_rd_level_i + (FIFO_ADDR_W + 1)'(pf_valid_q);
   assign empty        = fifo_rd_empty_i & ~pf_valid_q;
   // Zero threshold keeps the interrupt off
   assign interrupt_o  = (thresh_q != '0) && (DATA_W'(level) >= thresh_q);

   always_comb begin
      count_bin[DATA_W-1] = count_gray_i[DATA_W-1];
      for (int i = DATA_W - 2; i >= 0; i--) begin
         count_bin[i] = count_bin[i+1] ^ count_gray_i[i];
      end
   end

   always_comb begin
      rd_data = '0;
      case (addr)
         CSR_CTRL:   rd_data = DATA_W'({soft_reset_o, enable_o});
         CSR_STATUS: rd_data = DATA_W'({tlast_seen_i, fifo_rd_full_i, empty});
         CSR_DATA:   rd_data = pf_valid_q ? pf_data_q : '0;
         CSR_LEVEL:  rd_data = DATA_W'(level);
         CSR_NWORDS: rd_data = count_bin;
         CSR_THRESH: rd_data = thresh_q;
         default:    rd_data = '0;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wb_ack_o     <= 1'b0;
         enable_o     <= 1'b0;
         soft_reset_o <= 1'b0;
         thresh_q     <= '0;
         pf_valid_q   <= 1'b0;
      end else begin
         wb_ack_o <= req;
         if (wr_req && addr == CSR_CTRL) begin
            enable_o     <= wb_dat_i[0];
            soft_reset_o <= wb_dat_i[1];
         end
         if (wr_req && addr == CSR_THRESH) thresh_q <= wb_dat_i;
         if (soft_reset_o) pf_valid_q <= 1'b0;
         else if (fifo_rd_en_o) pf_valid_q <= 1'b1;
         else if (data_pop) pf_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fifo_rd_en_o) pf_data_q <= fifo_rd_data_i;
      if (rd_req) wb_dat_o <= rd_data;
   end

   // A held prefetch word only leaves through a DATA read or soft reset
   a_prefetch_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      pf_valid_q && !data_pop && !soft_reset_o |=> pf_valid_q && $stable(pf_data_q));

endmodule

//--- hw/axis_in_top.sv
//********************************************************************
// Stream input peripheral: packs AXI-Stream bytes into words read
// over Wishbone, with a clock crossing FIFO in between
//********************************************************************

`timescale 1ns/1ps

module axis_in_top #(
   parameter int DATA_W      = axis_in_pkg::DATA_W,
   parameter int TDATA_W     = axis_in_pkg::TDATA_W,
   parameter int FIFO_ADDR_W = axis_in_pkg::FIFO_ADDR_W
) (
   input  logic                               clk_i,
   input  logic                               axis_clk_i,
   input  logic                               arst_n_i,
   // Wishbone slave
   input  logic                               wb_cyc_i,
   input  logic                               wb_stb_i,
   input  logic                               wb_we_i,
   input  logic [axis_in_pkg::CSR_ADDR_W-1:0] wb_adr_i,
   input  logic [                DATA_W-1:0]  wb_dat_i,
   input  logic [              DATA_W/8-1:0]  wb_sel_i,
   output logic [                DATA_W-1:0]  wb_dat_o,
   output logic                               wb_ack_o,
   // Stream input
   input  logic                               axis_tvalid_i,
   input  logic [               TDATA_W-1:0]  axis_tdata_i,
   input  logic                               axis_tlast_i,
   output logic                               axis_tready_o,
   output logic                               interrupt_o
);

   // System clock domain
   logic                 enable, soft_reset, fifo_rd_en, fifo_rd_empty, fifo_rd_full;
   logic [   DATA_W-1:0] fifo_rd_data;
   logic [FIFO_ADDR_W:0] fifo_rd_level;
   logic [     DATA_W:0] status_clk;

   // Stream clock domain
   logic                axis_enable, axis_soft_reset, fifo_wr_en, fifo_wr_full, tlast_seen;
   logic [TDATA_W-1:0]  fifo_wr_data;
   logic [ DATA_W-1:0]  count_gray;

   axis_in_csr #(.DATA_W(DATA_W), .FIFO_ADDR_W(FIFO_ADDR_W)) csr (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .wb_cyc_i       (wb_cyc_i),
      .wb_stb_i       (wb_stb_i),
      .wb_we_i        (wb_we_i),
      .wb_adr_i       (wb_adr_i),
      .wb_dat_i       (wb_dat_i),
      .wb_sel_i       (wb_sel_i),
      .wb_dat_o       (wb_dat_o),
      .wb_ack_o       (wb_ack_o),
      .enable_o       (enable),
      .soft_reset_o   (soft_reset),
      .fifo_rd_en_o   (fifo_rd_en),
      .fifo_rd_data_i (fifo_rd_data),
      .fifo_rd_empty_i(fifo_rd_empty),
      .fifo_rd_full_i (fifo_rd_full),
      .fifo_rd_level_i(fifo_rd_level),
      .count_gray_i   (status_clk[DATA_W-1:0]),
      .tlast_seen_i   (status_clk[DATA_W]),
      .interrupt_o    (interrupt_o)
   );

   axis_in_write_ctrl #(.TDATA_W(TDATA_W), .DATA_W(DATA_W)) write_ctrl (
      .axis_clk_i    (axis_clk_i),
      .arst_n_i      (arst_n_i),
      .sw_rst_i      (axis_soft_reset),
      .sw_enable_i   (axis_enable),
      .axis_tvalid_i (axis_tvalid_i),
      .axis_tdata_i  (axis_tdata_i),
      .axis_tlast_i  (axis_tlast_i),
      .axis_tready_o (axis_tready_o),
      .fifo_full_i   (fifo_wr_full),
      .fifo_wr_en_o  (fifo_wr_en),
      .fifo_wr_data_o(fifo_wr_data),
      .count_gray_o  (count_gray),
      .tlast_seen_o  (tlast_seen)
   );

   axis_in_async_fifo #(
      .DATA_W     (DATA_W),
      .TDATA_W    (TDATA_W),
      .FIFO_ADDR_W(FIFO_ADDR_W)
   ) fifo (
      .arst_n_i (arst_n_i),
      .w_clk_i  (axis_clk_i),
      .w_rst_i  (axis_soft_reset),
      .w_en_i   (fifo_wr_en),
      .w_data_i (fifo_wr_data),
      .w_full_o (fifo_wr_full),
      .r_clk_i  (clk_i),
      .r_rst_i  (soft_reset),
      .r_en_i   (fifo_rd_en),
      .r_data_o (fifo_rd_data),
      .r_empty_o(fifo_rd_empty),
      .r_full_o (fifo_rd_full),
      .r_level_o(fifo_rd_level)
   );

   // Control bits into the stream domain
   axis_in_sync #(.WIDTH(1)) enable_sync (
      .clk_i   (axis_clk_i),
      .arst_n_i(arst_n_i),
      .data_i  (enable),
      .data_o  (axis_enable)
   );

   axis_in_sync #(.WIDTH(1)) soft_reset_sync (
      .clk_i   (axis_clk_i),
      .arst_n_i(arst_n_i),
      .data_i  (soft_reset),
      .data_o  (axis_soft_reset)
   );

   // Gray count with the tlast flag on top
   axis_in_sync #(.WIDTH(DATA_W + 1)) status_sync (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .data_i  ({tlast_seen, count_gray}),
      .data_o  (status_clk)
   );

endmodule

//--- tests/axis_in_clk_gen.sv
//********************************************************************
// Free running testbench clock with a settable phase offset
//********************************************************************

`timescale 1ns/1ps

module axis_in_clk_gen #(
   parameter real PERIOD_NS = 4.0,
   parameter real PHASE_NS  = 0.0
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      #(PHASE_NS);
      forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
   end

endmodule

//--- tests/axis_in_tb.sv
//********************************************************************
// Directed testbench for the stream input peripheral
// Drives the stream and Wishbone ports, checks against a word model
//********************************************************************

`timescale 1ns/1ps

module axis_in_tb;

   import axis_in_pkg::*;

   localparam int          PACK           = DATA_W / TDATA_W;
   localparam int          ACK_BOUND      = 8;
   localparam int          STALL_BOUND    = 40;
   localparam int          POLL_BOUND     = 50;
   localparam logic [31:0] LFSR_SEED      = 32'hfda45cdc;
   localparam logic [31:0] LFSR_TAPS      = 32'h80200003;
   // Run time bound: stream tests x longest burst x time per beat
   localparam int          N_STREAM_TESTS = 5;
   localparam int          MAX_BEATS      = 40;
   localparam int          BEAT_BOUND_NS  = 100;
   localparam int          WATCHDOG_NS    = N_STREAM_TESTS * MAX_BEATS * BEAT_BOUND_NS;

   logic                  clk, axis_clk, arst_n;
   logic                  wb_cyc, wb_stb, wb_we, wb_ack;
   logic [CSR_ADDR_W-1:0] wb_adr;
   logic [DATA_W-1:0]     wb_wdat, wb_dat;
   logic [DATA_W/8-1:0]   wb_sel;
   logic                  axis_tvalid, axis_tlast, axis_tready, interrupt;
   logic [TDATA_W-1:0]    axis_tdata;

   // Stimulus bytes not yet accepted, and the expected words
   logic [TDATA_W-1:0]    tx_q[$];
   logic [DATA_W-1:0]     exp_q[$];
   logic [DATA_W-1:0]     acc_word;
   int                    acc_n;
   logic [31:0]           lfsr_q;
   string                 test_name;

   axis_in_clk_gen #(.PERIOD_NS(4.0), .PHASE_NS(0.0)) sys_clk_gen (.clk_o(clk));
   axis_in_clk_gen #(.PERIOD_NS(4.0), .PHASE_NS(1.0)) axis_clk_gen (.clk_o(axis_clk));

   axis_in_top #(
      .DATA_W     (DATA_W),
      .TDATA_W    (TDATA_W),
      .FIFO_ADDR_W(FIFO_ADDR_W)
   ) UUT (
      .clk_i        (clk),
      .axis_clk_i   (axis_clk),
      .arst_n_i     (arst_n),
      .wb_cyc_i     (wb_cyc),
      .wb_stb_i     (wb_stb),
      .wb_we_i      (wb_we),
      .wb_adr_i     (wb_adr),
      .wb_dat_i     (wb_wdat),
      .wb_sel_i     (wb_sel),
      .wb_dat_o     (wb_dat),
      .wb_ack_o     (wb_ack),
      .axis_tvalid_i(axis_tvalid),
      .axis_tdata_i (axis_tdata),
      .axis_tlast_i (axis_tlast),
      .axis_tready_o(axis_tready),
      .interrupt_o  (interrupt)
   );

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) return (s >> 1) ^ LFSR_TAPS;
      return s >> 1;
   endfunction

   task automatic stop_on_error();
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first error in test %s", test_name);
   endtask

   task automatic expect_value(input string what, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
      assert (act === exp) else begin
         $display("mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
         stop_on_error();
      end
   endtask

   // Packs bytes low first, a tlast byte closes the word with zeros above
   task automatic model_byte(input logic [TDATA_W-1:0] b, input bit last);
      acc_word[acc_n*TDATA_W +: TDATA_W] = b;
      acc_n++;
      if (acc_n == PACK || last) begin
         exp_q.push_back(acc_word);
         acc_word = '0;
         acc_n    = 0;
      end
   endtask

   task automatic gen_bytes(input int n, input bit last);
      logic [TDATA_W-1:0] b;
      for (int i = 0; i < n; i++) begin
         for (int k = 0; k < TDATA_W; k++) begin
            b[k]   = lfsr_q[0];
            lfsr_q = lfsr_step(lfsr_q);
         end
         tx_q.push_back(b);
         model_byte(b, last && (i == n - 1));
      end
   endtask

   task automatic wait_ack(input csr_addr_e addr);
      int waited;
      waited = 0;
      while (!wb_ack && waited < ACK_BOUND) begin
         @(posedge clk);
         #0.5;
         waited++;
      end
      assert (wb_ack) else begin
         $display("%s: no Wishbone ack on %s within %0d cycles", test_name, addr.name(),
                  ACK_BOUND);
         stop_on_error();
      end
   endtask

   task automatic wb_write(input csr_addr_e addr, input logic [DATA_W-1:0] data);
      @(posedge clk);
      #0.5;
      wb_adr  = addr;
      wb_wdat = data;
      wb_we   = 1'b1;
      wb_cyc  = 1'b1;
      wb_stb  = 1'b1;
      wait_ack(addr);
      wb_cyc  = 1'b0;
      wb_stb  = 1'b0;
      wb_we   = 1'b0;
   endtask

   task automatic wb_read(input csr_addr_e addr, output logic [DATA_W-1:0] data);
      @(posedge clk);
      #0.5;
      wb_adr = addr;
      wb_we  = 1'b0;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wait_ack(addr);
      data   = wb_dat;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   task automatic read_expect(input csr_addr_e addr, input logic [DATA_W-1:0] exp);
      logic [DATA_W-1:0] d;
      wb_read(addr, d);
      expect_value(addr.name(), exp, d);
   endtask

   task automatic read_data_word();
      logic [DATA_W-1:0] d;
      wb_read(CSR_DATA, d);
      assert (exp_q.size() > 0) else begin
         $display("%s: DATA read with no word left in the model", test_name);
         stop_on_error();
      end
      expect_value("DATA word", exp_q.pop_front(), d);
   endtask

   task automatic poll_level(input int target);
      logic [DATA_W-1:0] lvl;
      int tries;
      tries = 0;
      wb_read(CSR_LEVEL, lvl);
      while (lvl != target && tries < POLL_BOUND) begin
         wb_read(CSR_LEVEL, lvl);
         tries++;
      end
      assert (lvl == target) else begin
         $display("%s: LEVEL stuck at %0d while waiting for %0d", test_name, lvl, target);
         stop_on_error();
      end
   endtask

   // Offers n queued bytes, gives up after stall_max cycles without a transfer
   task automatic send_beats(input int n, input bit last, input int stall_max,
                             output int sent);
      int stall;
      bit took;
      sent  = 0;
      stall = 0;
      @(posedge axis_clk);
      #0.5;
      while (sent < n && stall < stall_max) begin
         axis_tvalid = 1'b1;
         axis_tdata  = tx_q[0];
         axis_tlast  = last && (sent == n - 1);
         // Ready only depends on stream domain registers
         took = axis_tready;
         @(posedge axis_clk);
         #0.5;
         if (took) begin
            void'(tx_q.pop_front());
            sent++;
            stall = 0;
         end else begin
            stall++;
         end
      end
      axis_tvalid = 1'b0;
      axis_tlast  = 1'b0;
   endtask

   task automatic send_all(input int n, input bit last);
      int sent;
      send_beats(n, last, STALL_BOUND, sent);
      expect_value("accepted beats", n, sent);
   endtask

   task automatic expect_tready_low(input int cycles);
      repeat (cycles) begin
         @(posedge axis_clk);
         #0.5;
         assert (!axis_tready) else begin
            $display("%s: tready went high while the stream must be stalled", test_name);
            stop_on_error();
         end
      end
   endtask

   task automatic soft_reset();
      wb_write(CSR_CTRL, 32'h2);
      // Long enough for both pointer crossings to settle at zero
      repeat (10) @(posedge clk);
      wb_write(CSR_CTRL, 32'h0);
      repeat (4) @(posedge clk);
      tx_q.delete();
      exp_q.delete();
      acc_word = '0;
      acc_n    = 0;
   endtask

   task automatic test_reset_state();
      test_name = "reset_state";
      read_expect(CSR_CTRL, 0);
      read_expect(CSR_THRESH, 0);
      read_expect(CSR_LEVEL, 0);
      read_expect(CSR_NWORDS, 0);
      read_expect(CSR_STATUS, 32'h1);
      expect_value("tready", 0, axis_tready);
      expect_value("interrupt", 0, interrupt);
      expect_tready_low(10);
   endtask

   task automatic test_full_packet();
      test_name = "full_packet";
      wb_write(CSR_CTRL, 32'h1);
      gen_bytes(8, 1'b1);
      send_all(8, 1'b1);
      poll_level(2);
      read_expect(CSR_NWORDS, 8);
      read_expect(CSR_STATUS, 32'h4);
      read_data_word();
      read_data_word();
      expect_tready_low(10);
      read_expect(CSR_DATA, 0);
      read_expect(CSR_STATUS, 32'h5);
   endtask

   task automatic test_padding();
      test_name = "padding";
      soft_reset();
      wb_write(CSR_CTRL, 32'h1);
      gen_bytes(5, 1'b1);
      send_all(5, 1'b1);
      poll_level(2);
      read_expect(CSR_NWORDS, 5);
      read_data_word();
      read_data_word();
   endtask

   task automatic test_back_pressure();
      int sent;
      test_name = "back_pressure";
      soft_reset();
      wb_write(CSR_CTRL, 32'h1);
      gen_bytes(40, 1'b0);
      // FIFO holds 16 bytes and the prefetch register one more word
      send_beats(40, 1'b0, STALL_BOUND, sent);
      expect_value("beats accepted before stall", 20, sent);
      poll_level(5);
      read_expect(CSR_STATUS, 32'h2);
      repeat (5) read_data_word();
      send_all(20, 1'b0);
      poll_level(5);
      repeat (5) read_data_word();
      read_expect(CSR_STATUS, 32'h1);
   endtask

   task automatic test_threshold_irq();
      test_name = "threshold_irq";
      soft_reset();
      wb_write(CSR_CTRL, 32'h1);
      wb_write(CSR_THRESH, 2);
      gen_bytes(4, 1'b0);
      send_all(4, 1'b0);
      poll_level(1);
      repeat (10) begin
         @(posedge clk);
         #0.5;
         expect_value("interrupt at one word", 0, interrupt);
      end
      gen_bytes(4, 1'b0);
      send_all(4, 1'b0);
      poll_level(2);
      expect_value("interrupt at two words", 1, interrupt);
      read_data_word();
      expect_value("interrupt after one DATA read", 0, interrupt);
      read_data_word();
   endtask

   task automatic test_soft_reset();
      test_name = "soft_reset";
      soft_reset();
      wb_write(CSR_CTRL, 32'h1);
      // One full word plus a partial one
      gen_bytes(6, 1'b0);
      send_all(6, 1'b0);
      poll_level(1);
      soft_reset();
      read_expect(CSR_LEVEL, 0);
      read_expect(CSR_NWORDS, 0);
      read_expect(CSR_STATUS, 32'h1);
      wb_write(CSR_CTRL, 32'h1);
      gen_bytes(4, 1'b1);
      send_all(4, 1'b1);
      poll_level(1);
      read_expect(CSR_NWORDS, 4);
      read_data_word();
      read_expect(CSR_STATUS, 32'h5);
   endtask

   initial begin
      arst_n      = 1'b0;
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      wb_adr      = '0;
      wb_wdat     = '0;
      wb_sel      = '1;
      axis_tvalid = 1'b0;
      axis_tdata  = '0;
      axis_tlast  = 1'b0;
      lfsr_q      = LFSR_SEED;
      acc_word    = '0;
      acc_n       = 0;
      test_name   = "startup";
      repeat (3) @(posedge clk);
      #0.5;
      arst_n = 1'b1;
      test_reset_state();
      test_full_packet();
      test_padding();
      test_back_pressure();
      test_threshold_irq();
      test_soft_reset();
      $display("SIMULATION PASSED");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog: tests still running after %0d ns", WATCHDOG_NS);
      $display("SIMULATION FAILED");
      $fatal(1, "watchdog timeout");
   end

endmodule

//--- axis_in_top.f
hw/axis_in_pkg.sv
hw/axis_in_sync.sv
hw/axis_in_async_fifo.sv
hw/axis_in_write_ctrl.sv
hw/axis_in_csr.sv
hw/axis_in_top.sv
tests/axis_in_clk_gen.sv
tests/axis_in_tb.sv

//--- Makefile
# Verilator build and run of the stream input peripheral testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module axis_in_tb \
		-f axis_in_top.f -o axis_in_sim

run: compile
	./obj_dir/axis_in_sim | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
